// File: build.f
verilog/stim_pkg.sv
verilog/umi_stimulus.sv
verilog/stim_fifo.sv
verilog/stim_signature.sv
verilog/stim_subsystem.sv
tests/stim_subsystem_chk.sv
tests/tb_stim_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the stimulus subsystem testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log
OBJ=obj_dir

rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
   -f build.f \
   --top-module tb_stim_subsystem \
   -Mdir "$OBJ" -o tb_sim

"./$OBJ/tb_sim" | tee "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
   echo "run_sim.sh: testbench reported failure"
   exit 1
fi

echo "run_sim.sh: done"

// File: tests/stim_subsystem_chk.sv
//##############################
// Handshake, FIFO occupancy and done state
// assertions bound to the subsystem top
//##############################

module stim_subsystem_chk #(
   parameter int UW         = stim_pkg::stim_uw_def, // Payload width
   parameter int FIFO_DEPTH = 4                      // Buffer entries
) (
   input logic          dut_clk,
   input logic          nreset,
   input logic          stim_valid,
   input logic          stim_ready,
   input logic [UW-1:0] stim_packet,
   input logic          stim_done,
   input logic          fifo_valid,
   input logic          fifo_ready,
   input logic [UW-1:0] fifo_packet
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [7:0] occ;      // Entries held per the handshakes
   logic       in_beat;  // Player to FIFO
   logic       out_beat; // FIFO to sink

   assign in_beat  = stim_valid && stim_ready;
   assign out_beat = fifo_valid && fifo_ready;

   always_ff @(posedge dut_clk or negedge nreset) begin
      if (!nreset) begin
         occ <= '0;
      end else begin
         occ <= occ + 8'(in_beat) - 8'(out_beat);
      end
   end

   //#############################
   // Properties
   //#############################
   a_stim_hold: assert property (@(posedge dut_clk) disable iff (!nreset)
      stim_valid && !stim_ready |=> stim_valid && $stable(stim_packet))
      else $error("Player dropped or changed its packet while stim_ready was low");

   a_fifo_hold: assert property (@(posedge dut_clk) disable iff (!nreset)
      fifo_valid && !fifo_ready |=> fifo_valid && $stable(fifo_packet))
      else $error("FIFO dropped or changed its head while fifo_ready was low");

   a_no_overflow: assert property (@(posedge dut_clk) disable iff (!nreset)
      occ <= 8'(FIFO_DEPTH))
      else $error("FIFO holds more entries than its depth");

   a_full_ready: assert property (@(posedge dut_clk) disable iff (!nreset)
      (occ == 8'(FIFO_DEPTH)) |-> !stim_ready)
      else $error("FIFO full but stim_ready still high");

   a_done_sticky: assert property (@(posedge dut_clk) disable iff (!nreset)
      stim_done |=> stim_done)
      else $error("Player left the done state before reset");

   // Done and drained, so no new packet may reach the sink
   a_no_beat_done: assert property (@(posedge dut_clk) disable iff (!nreset)
      stim_done && !fifo_valid |=> !fifo_valid)
      else $error("Packet reached the FIFO output after stim_done and drain");

endmodule

bind stim_subsystem stim_subsystem_chk #(
   .UW         (UW),
   .FIFO_DEPTH (FIFO_DEPTH)
) i_chk (
   .dut_clk     (dut_clk),
   .nreset      (nreset),
   .stim_valid  (stim_valid),
   .stim_ready  (stim_ready),
   .stim_packet (stim_packet),
   .stim_done   (stim_done),
   .fifo_valid  (fifo_valid),
   .fifo_ready  (fifo_ready),
   .fifo_packet (fifo_packet)
);

// File: tests/tb_stim_subsystem.sv
//##############################
// Table-driven testbench for the stimulus subsystem
// with reference signature model and watchdog
//##############################

module tb_stim_subsystem;
   timeunit 1ns;
   timeprecision 100ps;
   import stim_pkg::*;

   localparam int UW         = stim_uw_def;
   localparam int CW         = stim_cw_def;
   localparam int PW         = CW - 1;          // Pause field bits
   localparam int DEPTH      = stim_depth_def;
   localparam int FIFO_DEPTH = 4;
   localparam int CLK_PERIOD = 8;               // dut_clk, ns
   localparam int EXT_PERIOD = 10;              // ext_clk, ns
   localparam int RST_CYCLES = 16;
   localparam int NROWS      = 5;

   // One scenario per row
   typedef struct packed {
      int          n_pkts;    // Entries before the end marker
      logic [31:0] base;      // Payload base, mixed with random bits
      int          max_pause; // Largest coded pause
      int          stall_pct; // Chance of sink_stall per cycle
   } row_t;

   row_t rows [NROWS] = '{
      '{8,  32'h1000_0000, 0, 0},  // Plain replay in memory order
      '{16, 32'h2200_0000, 6, 0},  // Random pauses
      '{24, 32'h3300_0000, 2, 60}, // Heavy back-pressure
      '{0,  32'h4400_0000, 0, 25}, // End marker first
      '{10, 32'h5500_0000, 3, 35}  // Reload after a new reset
   };

   logic                 dut_clk = 1'b0;
   logic                 ext_clk = 1'b0;
   logic                 nreset;
   logic                 ext_valid;
   logic [UW+CW-1:0]     ext_packet;
   logic                 load;
   logic                 go;
   logic                 sink_stall;
   logic [sig_width-1:0] sig_value;
   logic [15:0]          sig_count;
   logic                 run_done;

   int                   seed = 36592;
   int                   cur_row;
   int                   checks;
   int                   value_errors;
   int                   other_errors;
   logic [sig_width-1:0] exp_sig; // Model signature
   logic [15:0]          exp_cnt; // Model packet count

   always #(CLK_PERIOD / 2) dut_clk = !dut_clk;
   always #(EXT_PERIOD / 2) ext_clk = !ext_clk;

   stim_subsystem #(
      .UW         (UW),
      .CW         (CW),
      .DEPTH      (DEPTH),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) i_dut (
      .nreset     (nreset),
      .dut_clk    (dut_clk),
      .ext_clk    (ext_clk),
      .ext_valid  (ext_valid),
      .ext_packet (ext_packet),
      .load       (load),
      .go         (go),
      .sink_stall (sink_stall),
      .sig_value  (sig_value),
      .sig_count  (sig_count),
      .run_done   (run_done)
   );

   //#############################
   // Reference model and checks
   //#############################
   // Rotate left by one, then XOR the sized payload
   function automatic logic [sig_width-1:0] model_step(
      input logic [sig_width-1:0] sig,
      input logic [UW-1:0]        pay
   );
      logic [sig_width-1:0] rot;
      rot = (sig << 1) | (sig >> (sig_width - 1));
      return rot ^ sig_width'(pay);
   endfunction

   // Cycle allowance for one replay
   function automatic int row_budget(input row_t row);
      return (row.n_pkts + 1) * (row.max_pause + 2) * 8 + 100;
   endfunction

   task automatic check_sig(input string name, input logic [sig_width-1:0] got,
                            input logic [sig_width-1:0] exp);
      checks++;
      if (got !== exp) begin
         value_errors++;
         $display("Fail %s: got 0x%h, expected 0x%h (row %0d)", name, got, exp, cur_row);
      end
   endtask

   task automatic check_count(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         value_errors++;
         $display("Fail %s: got 0x%h, expected 0x%h (row %0d)", name, got, exp, cur_row);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         value_errors++;
         $display("Fail %s: got 0x%h, expected 0x%h (row %0d)", name, got, exp, cur_row);
      end
   endtask

   //#############################
   // Sequencing tasks
   //#############################
   task automatic apply_reset();
      @(posedge dut_clk);
      nreset     <= 1'b0;
      go         <= 1'b0; // Drop the previous start request
      sink_stall <= 1'b0;
      repeat (RST_CYCLES) @(posedge dut_clk);
      nreset <= 1'b1;
      repeat (2) @(negedge dut_clk);
   endtask

   // Everything quiet before go
   task automatic check_idle();
      check_flag("stim_valid", i_dut.stim_valid, 1'b0);
      check_flag("stim_done", i_dut.stim_done, 1'b0);
      check_flag("run_done", run_done, 1'b0);
      check_count("sig_count", sig_count, 16'h0000);
      check_sig("sig_value", sig_value, sig_seed);
   endtask

   // Write the row's entries and end marker, build the expected result
   task automatic load_stream(input row_t row);
      logic [UW-1:0] pay;
      logic [PW-1:0] pause;
      exp_sig = sig_seed;
      exp_cnt = '0;
      for (int i = 0; i < row.n_pkts; i++) begin
         pay   = row.base ^ $random(seed);
         pause = (row.max_pause == 0) ? '0 : PW'({$random(seed)} % (row.max_pause + 1));
         @(posedge ext_clk);
         ext_valid  <= 1'b1;
         load       <= 1'b1;
         ext_packet <= {pay, pause, 1'b1}; // Valid flag set
         exp_sig = model_step(exp_sig, pay);
         exp_cnt = exp_cnt + 16'd1;
      end
      @(posedge ext_clk);
      ext_packet <= {row.base, {PW{1'b0}}, 1'b0}; // End marker
      ext_valid  <= 1'b1;
      load       <= 1'b1;
      @(posedge ext_clk);
      ext_valid <= 1'b0;
      load      <= 1'b0;
   endtask

   // Random back-pressure until run_done, bounded by the row budget
   task automatic wait_run_done(input row_t row);
      int cycles;
      cycles = 0;
      while (!run_done && cycles < row_budget(row)) begin
         @(posedge dut_clk);
         sink_stall <= ({$random(seed)} % 100) < row.stall_pct;
         @(negedge dut_clk);
         cycles++;
      end
      if (!run_done) begin
         other_errors++;
         $display("Row %0d: run_done did not rise within %0d cycles", cur_row, cycles);
      end
      @(posedge dut_clk);
      sink_stall <= 1'b0;
   endtask

   //#############################
   // Main sequence
   //#############################
   initial begin
      nreset     = 1'b0;
      ext_valid  = 1'b0;
      ext_packet = '0;
      load       = 1'b0;
      go         = 1'b0;
      sink_stall = 1'b0;
      checks       = 0;
      value_errors = 0;
      other_errors = 0;
      for (int r = 0; r < NROWS; r++) begin
         cur_row = r;
         apply_reset();
         check_idle();
         load_stream(rows[r]);
         @(posedge dut_clk);
         go <= 1'b1; // Held until the next reset
         wait_run_done(rows[r]);
         @(negedge dut_clk);
         check_flag("run_done", run_done, 1'b1);
         check_flag("stim_done", i_dut.stim_done, 1'b1);
         check_count("sig_count", sig_count, exp_cnt);
         check_sig("sig_value", sig_value, exp_sig);
      end
      $display("Checks: %0d  value errors: %0d  other errors: %0d",
               checks, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // Watchdog, twice the sum of all row allowances
   initial begin : watchdog
      int limit_ns;
      limit_ns = 0;
      for (int r = 0; r < NROWS; r++) begin
         limit_ns += (row_budget(rows[r]) + RST_CYCLES + 20) * CLK_PERIOD;
         limit_ns += (rows[r].n_pkts + 4) * EXT_PERIOD; // Load time
      end
      #(2 * limit_ns);
      $display("Watchdog expired after %0t, the run did not finish", $time);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: verilog/stim_fifo.sv
//##############################
// Synchronous FIFO, valid/ready on both sides
//##############################

module stim_fifo #(
   parameter int W     = stim_pkg::stim_uw_def, // Data width
   parameter int DEPTH = 4                      // Entries
) (
   input  logic         dut_clk,
   input  logic         nreset,
   input  logic         in_valid,
   input  logic [W-1:0] in_data,
   output logic         in_ready,  // Not full
   output logic         out_valid, // Not empty
   output logic [W-1:0] out_data,
   input  logic         out_ready
);

   localparam int AW   = (DEPTH > 1) ? $clog2(DEPTH) : 1; // Pointer bits
   localparam int CNTW = $clog2(DEPTH + 1);               // Occupancy bits

   logic [W-1:0]    mem [DEPTH];
   logic [AW-1:0]   wr_ptr;
   logic [AW-1:0]   rd_ptr;
   logic [CNTW-1:0] count;
   logic            push;
   logic            pop;

   // Pointer advance with wrap at DEPTH
   function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
      logic [AW-1:0] nxt;
      nxt = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
      return nxt;
   endfunction

   // Flags from occupancy
   assign in_ready  = (count != CNTW'(DEPTH));
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr]; // Head entry, stable until popped

   assign push = in_valid && in_ready;   // Never past full
   assign pop  = out_valid && out_ready; // Never past empty

   //#############################
   // Storage
   //#############################
   always_ff @(posedge dut_clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   //#############################
   // Pointers and count
   //#############################
   always_ff @(posedge dut_clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         // Simultaneous push and pop keeps the count
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: verilog/stim_pkg.sv
//##############################
// Shared widths, control word layout, player states
// and signature constants of the stimulus subsystem
//##############################

package stim_pkg;

   // Default sizes
   localparam int stim_uw_def    = 32;  // Payload bits
   localparam int stim_cw_def    = 8;   // Control bits
   localparam int stim_depth_def = 256; // Memory entries

   //#############################
   // Control word layout
   //#############################
   // Word stored in memory is {payload, control}
   localparam int ctl_valid_bit = 0; // Cleared on the end marker
   localparam int ctl_pause_lsb = 1; // Pause count in the upper bits

   // Player FSM states
   typedef enum logic [1:0] {
      st_idle   = 2'b00, // Waiting for go
      st_active = 2'b01, // Presenting entries
      st_pause  = 2'b10, // Idle gap after a packet
      st_done   = 2'b11  // End marker seen
   } stim_state_e;

   //#############################
   // Signature
   //#############################
   localparam int                   sig_width = 32;
   localparam logic [sig_width-1:0] sig_seed  = 32'h5a3c_96e1; // Value after reset

   // One step: rotate left by one, then XOR the payload
   function automatic logic [sig_width-1:0] sig_fold(
      input logic [sig_width-1:0] sig,
      input logic [sig_width-1:0] data
   );
      return {sig[sig_width-2:0], sig[sig_width-1]} ^ data;
   endfunction

endpackage

// File: verilog/stim_signature.sv
//##############################
// Signature sink: rotate-XOR fold, packet count
// and run completion flag
//##############################

module stim_signature #(
   parameter int UW = stim_pkg::stim_uw_def // Payload width
) (
   input  logic                          dut_clk,
   input  logic                          nreset,
   input  logic                          in_valid,
   input  logic [UW-1:0]                 in_packet,
   output logic                          in_ready,
   input  logic                          sink_stall, // External back-pressure
   input  logic                          stim_done,  // Producer finished
   output logic [stim_pkg::sig_width-1:0] sig_value,
   output logic [15:0]                   sig_count,
   output logic                          run_done
);
   import stim_pkg::*;

   logic                 accept;    // Packet taken this cycle
   logic [sig_width-1:0] fold_data; // Payload sized to the signature

   assign in_ready  = !sink_stall;
   assign accept    = in_valid && in_ready;
   assign fold_data = sig_width'(in_packet); // Zero-extend or truncate

   //#############################
   // Signature and count
   //#############################
   always_ff @(posedge dut_clk or negedge nreset) begin
      if (!nreset) begin
         sig_value <= sig_seed;
         sig_count <= '0;
      end else if (accept) begin
         sig_value <= sig_fold(sig_value, fold_data);
         sig_count <= sig_count + 1'b1; // Wraps past 16 bits
      end
   end

   //#############################
   // Completion
   //#############################
   // Producer done and buffer drained, so nothing is pending.
   // Last fold already landed on the accepting edge.
   always_ff @(posedge dut_clk or negedge nreset) begin
      if (!nreset) begin
         run_done <= 1'b0;
      end else if (stim_done && !in_valid) begin
         run_done <= 1'b1; // Held until reset
      end
   end

endmodule

// File: verilog/stim_subsystem.sv
//##############################
// Stimulus subsystem top: player, FIFO, signature sink
//##############################

module stim_subsystem #(
   parameter int UW         = stim_pkg::stim_uw_def,    // Payload width
   parameter int CW         = stim_pkg::stim_cw_def,    // Control width
   parameter int DEPTH      = stim_pkg::stim_depth_def, // Stimulus memory entries
   parameter int FIFO_DEPTH = 4                         // Buffer entries
) (
   input  logic                          nreset,
   input  logic                          dut_clk,
   // Load side
   input  logic                          ext_clk,
   input  logic                          ext_valid,
   input  logic [UW+CW-1:0]              ext_packet,
   input  logic                          load,
   input  logic                          go,         // Async start request
   // Sink side
   input  logic                          sink_stall,
   output logic [stim_pkg::sig_width-1:0] sig_value,
   output logic [15:0]                   sig_count,
   output logic                          run_done
);

   // Player to buffer
   logic          stim_valid;
   logic [UW-1:0] stim_packet;
   logic          stim_ready;
   logic          stim_done;
   // Buffer to sink
   logic          fifo_valid;
   logic [UW-1:0] fifo_packet;
   logic          fifo_ready;

   umi_stimulus #(
      .UW    (UW),
      .CW    (CW),
      .DEPTH (DEPTH)
   ) i_stim (
      .nreset      (nreset),
      .load        (load),
      .go          (go),
      .ext_clk     (ext_clk),
      .ext_valid   (ext_valid),
      .ext_packet  (ext_packet),
      .dut_clk     (dut_clk),
      .stim_ready  (stim_ready),
      .stim_valid  (stim_valid),
      .stim_packet (stim_packet),
      .stim_done   (stim_done)
   );

   stim_fifo #(
      .W     (UW),
      .DEPTH (FIFO_DEPTH)
   ) i_fifo (
      .dut_clk   (dut_clk),
      .nreset    (nreset),
      .in_valid  (stim_valid),
      .in_data   (stim_packet),
      .in_ready  (stim_ready),  // Not full
      .out_valid (fifo_valid),
      .out_data  (fifo_packet),
      .out_ready (fifo_ready)
   );

   stim_signature #(
      .UW (UW)
   ) i_sig (
      .dut_clk    (dut_clk),
      .nreset     (nreset),
      .in_valid   (fifo_valid),
      .in_packet  (fifo_packet),
      .in_ready   (fifo_ready),
      .sink_stall (sink_stall),
      .stim_done  (stim_done),
      .sig_value  (sig_value),
      .sig_count  (sig_count),
      .run_done   (run_done)
   );

endmodule

// File: verilog/umi_stimulus.sv
//##############################
// Memory-backed stimulus player: load write port,
// go synchronizer, replay FSM and pause counter
//##############################

module umi_stimulus #(
   parameter int UW    = stim_pkg::stim_uw_def,   // Payload width
   parameter int CW    = stim_pkg::stim_cw_def,   // Control width, at least 2
   parameter int DEPTH = stim_pkg::stim_depth_def // Memory entries
) (
   input  logic             nreset,     // Async reset, both domains
   input  logic             load,       // Enables memory writes
   input  logic             go,         // Start request, async to dut_clk
   input  logic             ext_clk,    // Load side clock
   input  logic             ext_valid,  // Load entry present
   input  logic [UW+CW-1:0] ext_packet, // {payload, control}
   input  logic             dut_clk,    // Replay clock
   input  logic             stim_ready, // Buffer not full
   output logic             stim_valid,
   output logic [UW-1:0]    stim_packet,
   output logic             stim_done   // End of replay
);
   import stim_pkg::*;

   localparam int AW = $clog2(DEPTH);      // Address bits
   localparam int PW = CW - ctl_pause_lsb; // Pause count bits

   logic [UW+CW-1:0] ram [DEPTH];
   logic [UW+CW-1:0] mem_data;    // Entry at rd_addr
   logic [AW-1:0]    wr_addr;
   logic [AW-1:0]    rd_addr;
   logic [AW-1:0]    rd_addr_nxt;
   logic [1:0]       go_sync;
   logic             start;
   stim_state_e      state;
   logic [PW-1:0]    pause_cnt;   // Cycles left in pause
   logic [PW-1:0]    pause_len;   // Coded pause of current entry
   logic             entry_valid;
   logic             beat;        // Transfer to the buffer

   //#############################
   // Load port, ext_clk domain
   //#############################
   always_ff @(posedge ext_clk or negedge nreset) begin
      if (!nreset) begin
         wr_addr <= '0;
      end else if (ext_valid && load) begin
         wr_addr <= wr_addr + 1'b1; // One entry per accepted edge
      end
   end

   always_ff @(posedge ext_clk) begin
      if (ext_valid && load) begin
         ram[wr_addr] <= ext_packet;
      end
   end

   // Two-stage synchronizer for go
   always_ff @(posedge dut_clk or negedge nreset) begin
      if (!nreset) begin
         go_sync <= '0;
      end else begin
         go_sync <= {go_sync[0], go};
      end
   end

   assign start = go_sync[1];

   //#############################
   // Read port, dut_clk domain
   //#############################
   // Read ahead at the next address so the following entry
   // is on mem_data right after a beat
   assign rd_addr_nxt = rd_addr + AW'(beat);

   always_ff @(posedge dut_clk or negedge nreset) begin
      if (!nreset) begin
         rd_addr <= '0;
      end else begin
         rd_addr <= rd_addr_nxt; // Held under back-pressure
      end
   end

   always_ff @(posedge dut_clk) begin
      mem_data <= ram[rd_addr_nxt];
   end

   // Entry decode
   assign entry_valid = mem_data[ctl_valid_bit];
   assign pause_len   = mem_data[CW-1:ctl_pause_lsb];
   assign stim_packet = mem_data[UW+CW-1:CW]; // Strip control bits

   // Handshake
   assign stim_valid = (state == st_active) && entry_valid;
   assign beat       = stim_valid && stim_ready;
   assign stim_done  = (state == st_done);

   //#############################
   // Replay FSM
   //#############################
   always_ff @(posedge dut_clk or negedge nreset) begin
      if (!nreset) begin
         state     <= st_idle;
         pause_cnt <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (start) begin
                  state <= st_active;
               end
            end
            st_active: begin
               if (!entry_valid) begin
                  state <= st_done; // End marker reached
               end else if (beat && (pause_len != '0)) begin
                  state     <= st_pause;
                  pause_cnt <= pause_len; // d cycles with valid low
               end
            end
            st_pause: begin
               pause_cnt <= pause_cnt - 1'b1;
               if (pause_cnt == PW'(1)) begin
                  state <= st_active; // Last gap cycle
               end
            end
            default: begin
               state <= st_done; // Sticky until reset
            end
         endcase
      end
   end

endmodule
